// ==== ni_core.f ====
src/ni_pkg.sv
src/ni_if.sv
src/ni_flit_fifo.sv
src/ni_packetizer.sv
src/ni_depacketizer.sv
src/ni_regs.sv
src/ni_core.sv
tests/ni_core_assert.sv
tests/ni_core_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
verilator --binary --timing --assert --top-module ni_core_tb -f ni_core.f -o ni_core_sim &&
    ./obj_dir/ni_core_sim | tee /dev/stderr | grep -q "Simulation passed" ||
    { echo "ni_core simulation did not pass"; exit 1; }

// ==== src/ni_core.sv ====
/* ni_core top: single channel network interface, send and receive paths with registers */
`timescale 1ns/10ps
`default_nettype none

module ni_core #(
    parameter int LB = 8
) (
    input  wire                      clk,
    input  wire                      reset,
    input  wire [ni_pkg::EAW-1:0]    current_e_addr_i,
    // network side
    output ni_pkg::flit_t            flit_out_o,
    output logic                     flit_out_wr_o,
    input  wire                      credit_in_i,
    input  ni_pkg::flit_t            flit_in_i,
    input  wire                      flit_in_wr_i,
    output logic                     credit_out_o,
    // word streams
    input  wire [ni_pkg::DW-1:0]     tx_data_i,
    input  wire                      tx_valid_i,
    output logic                     tx_ready_o,
    output logic [ni_pkg::DW-1:0]    rx_data_o,
    output logic                     rx_valid_o,
    input  wire                      rx_ready_i,
    // register bus
    input  wire                      reg_wr_i,
    input  wire                      reg_rd_i,
    input  ni_pkg::reg_addr_e        reg_addr_i,
    input  wire [ni_pkg::DW-1:0]     reg_wdata_i,
    output logic [ni_pkg::DW-1:0]    reg_rdata_o,
    output logic                     reg_ack_o,
    output logic                     irq_o
);

    ni_send_if send_if ();
    ni_recv_if recv_if ();

    ni_packetizer #(.LB(LB)) packetizer (
        .clk             (clk),
        .reset           (reset),
        .current_e_addr_i(current_e_addr_i),
        .credit_in_i     (credit_in_i),
        .tx_data_i       (tx_data_i),
        .tx_valid_i      (tx_valid_i),
        .flit_out_o      (flit_out_o),
        .flit_out_wr_o   (flit_out_wr_o),
        .tx_ready_o      (tx_ready_o),
        .send            (send_if.pkt_mp)
    );

    ni_depacketizer #(.LB(LB)) depacketizer (
        .clk         (clk),
        .reset       (reset),
        .flit_in_i   (flit_in_i),
        .flit_in_wr_i(flit_in_wr_i),
        .rx_ready_i  (rx_ready_i),
        .credit_out_o(credit_out_o),
        .rx_data_o   (rx_data_o),
        .rx_valid_o  (rx_valid_o),
        .recv        (recv_if.depkt_mp)
    );

    ni_regs regs (
        .clk        (clk),
        .reset      (reset),
        .reg_wr_i   (reg_wr_i),
        .reg_rd_i   (reg_rd_i),
        .reg_addr_i (reg_addr_i),
        .reg_wdata_i(reg_wdata_i),
        .reg_rdata_o(reg_rdata_o),
        .reg_ack_o  (reg_ack_o),
        .irq_o      (irq_o),
        .send       (send_if.regs_mp),
        .recv       (recv_if.regs_mp)
    );

endmodule

`default_nettype wire

// ==== src/ni_depacketizer.sv ====
/* receive path: drains the flit buffer, streams body words out
   and checks the tail CRC32 against the received body */
`timescale 1ns/10ps
`default_nettype none

module ni_depacketizer #(
    parameter int LB = 8
) (
    input  wire                      clk,
    input  wire                      reset,
    input  ni_pkg::flit_t            flit_in_i,
    input  wire                      flit_in_wr_i,
    input  wire                      rx_ready_i,
    output logic                     credit_out_o,
    output logic [ni_pkg::DW-1:0]    rx_data_o,
    output logic                     rx_valid_o,
    ni_recv_if.depkt_mp              recv
);
    import ni_pkg::*;

    flit_t            head;
    logic             not_empty;
    logic             pop;
    logic             is_body;
    logic             hdr_pop;
    logic             body_pop;
    logic             tail_pop;
    logic [SIZEW-1:0] body_cnt;
    logic [31:0]      crc;
    logic [EAW-1:0]   src_q;
    logic [HDW-1:0]   hdr_q;
    logic             got_q;
    logic             crc_err_q;

    ni_flit_fifo #(
        .LB(LB)
    ) flit_buf (
        .clk        (clk),
        .reset      (reset),
        .din_i      (flit_in_i),
        .wr_i       (flit_in_wr_i),
        .rd_i       (pop),
        .dout_o     (head),
        .not_empty_o(not_empty)
    );

    assign is_body  = (head.flag == FLAG_BODY);
    // header and tail pop at once, body waits for the consumer
    assign pop      = not_empty && (!is_body || rx_ready_i);
    assign hdr_pop  = pop && (head.flag == FLAG_HDR);
    assign tail_pop = pop && (head.flag == FLAG_TAIL);
    assign body_pop = pop && is_body;

    assign rx_valid_o   = not_empty && is_body;
    assign rx_data_o    = head.payload.data;
    assign credit_out_o = pop;              // one credit per popped flit

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            body_cnt  <= '0;
            crc       <= CRC_INIT;
            got_q     <= 1'b0;
            crc_err_q <= 1'b0;
        end else begin
            got_q <= tail_pop;
            if (hdr_pop) begin
                body_cnt <= '0;
                crc      <= CRC_INIT;
            end else if (body_pop) begin
                body_cnt <= body_cnt + 1'b1;
                crc      <= crc32_update(crc, head.payload.data);
            end
            if (tail_pop) begin
                crc_err_q <= (crc != head.payload.data);
            end
        end
    end

    // source info read through the header view
    always_ff @(posedge clk) begin
        if (hdr_pop) begin
            src_q <= head.payload.hdr.src_e_addr;
            hdr_q <= head.payload.hdr.hdr_data;
        end
    end

    assign recv.got        = got_q;
    assign recv.src_e_addr = src_q;
    assign recv.hdr_data   = hdr_q;
    assign recv.size       = body_cnt;
    assign recv.crc_err    = crc_err_q;

endmodule

`default_nettype wire

// ==== src/ni_flit_fifo.sv ====
/* receive flit buffer, first word fall through, LB entries */
`timescale 1ns/10ps
`default_nettype none

module ni_flit_fifo #(
    parameter int LB = 8
) (
    input  wire           clk,
    input  wire           reset,
    input  ni_pkg::flit_t din_i,
    input  wire           wr_i,
    input  wire           rd_i,
    output ni_pkg::flit_t dout_o,
    output logic          not_empty_o
);
    import ni_pkg::*;

    localparam int PW = (LB > 1) ? $clog2(LB) : 1;
    localparam int CW = $clog2(LB + 1);

    flit_t         mem [LB];
    logic [PW-1:0] wr_ptr;
    logic [PW-1:0] rd_ptr;
    logic [CW-1:0] count;   // occupancy

    always_ff @(posedge clk) begin
        if (wr_i) begin
            mem[wr_ptr] <= din_i;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_i) begin
                wr_ptr <= (wr_ptr == PW'(LB - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (rd_i) begin
                rd_ptr <= (rd_ptr == PW'(LB - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (wr_i && !rd_i) begin
                count <= count + 1'b1;
            end else if (!wr_i && rd_i) begin
                count <= count - 1'b1;
            end
        end
    end

    assign dout_o      = mem[rd_ptr];   // head is always visible
    assign not_empty_o = (count != '0);

endmodule

`default_nettype wire

// ==== src/ni_if.sv ====
/* send command and receive report links between the ni paths and the register block */
`timescale 1ns/10ps
`default_nettype none

interface ni_send_if;
    import ni_pkg::*;

    logic             start;        // one cycle, only while busy is low
    logic [EAW-1:0]   dest_e_addr;
    logic [HDW-1:0]   hdr_data;
    logic [SIZEW-1:0] size;         // body words, 1..255
    logic             busy;
    logic             sent;         // pulse after the tail flit

    modport regs_mp (
        output start, dest_e_addr, hdr_data, size,
        input  busy, sent
    );

    modport pkt_mp (
        input  start, dest_e_addr, hdr_data, size,
        output busy, sent
    );
endinterface

interface ni_recv_if;
    import ni_pkg::*;

    logic             got;          // pulse after the tail flit is popped
    logic [EAW-1:0]   src_e_addr;
    logic [HDW-1:0]   hdr_data;
    logic [SIZEW-1:0] size;
    logic             crc_err;

    modport depkt_mp (
        output got, src_e_addr, hdr_data, size, crc_err
    );

    modport regs_mp (
        input  got, src_e_addr, hdr_data, size, crc_err
    );
endinterface

`default_nettype wire

// ==== src/ni_packetizer.sv ====
/* send path: header, body and tail flits out of the tx word stream
   with credit based flow control and a CRC32 over the body words */
`timescale 1ns/10ps
`default_nettype none

module ni_packetizer #(
    parameter int LB = 8
) (
    input  wire                      clk,
    input  wire                      reset,
    input  wire [ni_pkg::EAW-1:0]    current_e_addr_i,
    input  wire                      credit_in_i,
    input  wire [ni_pkg::DW-1:0]     tx_data_i,
    input  wire                      tx_valid_i,
    output ni_pkg::flit_t            flit_out_o,
    output logic                     flit_out_wr_o,
    output logic                     tx_ready_o,
    ni_send_if.pkt_mp                send
);
    import ni_pkg::*;

    localparam int CW = $clog2(LB + 1);

    typedef enum logic [1:0] {S_IDLE, S_HEADER, S_BODY, S_TAIL} state_e;

    state_e           state;
    logic [CW-1:0]    credit_cnt;
    logic [EAW-1:0]   dest_q;
    logic [HDW-1:0]   hdr_q;
    logic [SIZEW-1:0] remain;       // body words still to go
    logic [31:0]      crc;
    logic             sent_q;
    logic             has_credit;
    logic             body_xfer;
    flit_t            flit_d;

    assign has_credit = (credit_cnt != '0);
    assign tx_ready_o = (state == S_BODY) && has_credit;
    assign body_xfer  = tx_ready_o && tx_valid_i;

    always_comb begin
        flit_d        = '0;
        flit_out_wr_o = 1'b0;
        case (state)
            S_HEADER: begin
                flit_d.flag                        = FLAG_HDR;
                flit_d.payload.hdr.dest_e_addr = dest_q;
                flit_d.payload.hdr.src_e_addr  = current_e_addr_i;
                flit_d.payload.hdr.hdr_data    = hdr_q;
                flit_out_wr_o                      = has_credit;
            end
            S_BODY: begin
                flit_d.flag         = FLAG_BODY;
                flit_d.payload.data = tx_data_i;
                flit_out_wr_o       = body_xfer;
            end
            S_TAIL: begin
                flit_d.flag         = FLAG_TAIL;
                flit_d.payload.data = crc;     // running crc of the body
                flit_out_wr_o       = has_credit;
            end
            default: ;
        endcase
    end

    assign flit_out_o = flit_d;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state  <= S_IDLE;
            sent_q <= 1'b0;
            remain <= '0;
            crc    <= CRC_INIT;
        end else begin
            sent_q <= 1'b0;
            case (state)
                S_IDLE: if (send.start) begin
                    state  <= S_HEADER;
                    remain <= send.size;
                end
                S_HEADER: if (has_credit) begin
                    state <= S_BODY;
                    crc   <= CRC_INIT;
                end
                S_BODY: if (body_xfer) begin
                    crc    <= crc32_update(crc, tx_data_i);
                    remain <= remain - 1'b1;
                    if (remain == SIZEW'(1)) begin
                        state <= S_TAIL;
                    end
                end
                S_TAIL: if (has_credit) begin
                    state  <= S_IDLE;
                    sent_q <= 1'b1;
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // header fields held for the whole packet
    always_ff @(posedge clk) begin
        if (state == S_IDLE && send.start) begin
            dest_q <= send.dest_e_addr;
            hdr_q  <= send.hdr_data;
        end
    end

    // one credit per flit written, one back per credit_in pulse
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            credit_cnt <= CW'(LB);
        end else if (flit_out_wr_o && !credit_in_i) begin
            credit_cnt <= credit_cnt - 1'b1;
        end else if (!flit_out_wr_o && credit_in_i) begin
            credit_cnt <= credit_cnt + 1'b1;
        end
    end

    assign send.busy = (state != S_IDLE);
    assign send.sent = sent_q;

endmodule

`default_nettype wire

// ==== src/ni_pkg.sv ====
/* ni shared definitions
   flit layout, register map and the CRC32 rule used on both paths */
`default_nettype none

package ni_pkg;

    localparam int EAW    = 8;          // endpoint address
    localparam int DW     = 32;         // data word
    localparam int SIZEW  = 8;          // packet size field
    localparam int HDW    = DW - 2 * EAW;
    localparam int FLIT_W = DW + 2;

    typedef enum logic [1:0] {
        FLAG_BODY = 2'b00,
        FLAG_TAIL = 2'b01,
        FLAG_HDR  = 2'b10
    } flit_flag_e;

    typedef struct packed {
        logic [HDW-1:0] hdr_data;
        logic [EAW-1:0] src_e_addr;
        logic [EAW-1:0] dest_e_addr;
    } hdr_view_t;

    // header flit vs body/tail flit view of the same word
    typedef union packed {
        hdr_view_t       hdr;
        logic [DW-1:0]   data;
    } flit_payload_u;

    typedef struct packed {
        flit_flag_e    flag;
        flit_payload_u payload;
    } flit_t;

    typedef enum logic [2:0] {
        REG_STATUS     = 3'd0,
        REG_CTRL_FLAGS = 3'd1,
        REG_SEND_DEST  = 3'd2,
        REG_SEND_SIZE  = 3'd3,
        REG_RECV_SRC   = 3'd4,
        REG_RECV_SIZE  = 3'd5
    } reg_addr_e;

    localparam int NFLAGS     = 4;      // sent, got, crc_err, invalid_req
    localparam int FLAG_LSB   = 1;      // flags sit above the busy bit
    localparam int ENABLE_LSB = 8;

    localparam logic [31:0] CRC_POLY = 32'h04C1_1DB7;
    localparam logic [31:0] CRC_INIT = 32'hFFFF_FFFF;

    // msb first, one bit step per data bit
    function automatic logic [31:0] crc32_update(input logic [31:0] crc,
                                                 input logic [DW-1:0] data);
        logic [31:0] c;
        c = crc;
        for (int i = DW - 1; i >= 0; i--) begin
            if (c[31] ^ data[i]) begin
                c = {c[30:0], 1'b0} ^ CRC_POLY;
            end else begin
                c = {c[30:0], 1'b0};
            end
        end
        return c;
    endfunction

endpackage

`default_nettype wire

// ==== src/ni_regs.sv ====
/* register slave: send setup, receive report, flags with enables and irq */
`timescale 1ns/10ps
`default_nettype none

module ni_regs (
    input  wire                      clk,
    input  wire                      reset,
    input  wire                      reg_wr_i,
    input  wire                      reg_rd_i,
    input  ni_pkg::reg_addr_e        reg_addr_i,
    input  wire [ni_pkg::DW-1:0]     reg_wdata_i,
    output logic [ni_pkg::DW-1:0]    reg_rdata_o,
    output logic                     reg_ack_o,
    output logic                     irq_o,
    ni_send_if.regs_mp               send,
    ni_recv_if.regs_mp               recv
);
    import ni_pkg::*;

    logic              req;
    logic              wr;
    logic              start_q;
    logic              size_wr;
    logic              bad_req;
    logic [EAW-1:0]    dest_q;
    logic [HDW-1:0]    send_hdr_q;
    logic [SIZEW-1:0]  size_q;
    logic [EAW-1:0]    rsrc_q;
    logic [HDW-1:0]    rhdr_q;
    logic [SIZEW-1:0]  rsize_q;
    logic [NFLAGS-1:0] flags;       // {invalid_req, crc_err, got, sent}
    logic [NFLAGS-1:0] enables;
    logic [NFLAGS-1:0] set_flags;
    logic [NFLAGS-1:0] clr_flags;
    logic [DW-1:0]     rdata_d;

    assign req     = (reg_wr_i || reg_rd_i) && !reg_ack_o;  // ack cycle is never a request
    assign wr      = req && reg_wr_i;
    assign size_wr = wr && (reg_addr_i == REG_SEND_SIZE);
    assign bad_req = size_wr && (send.busy || reg_wdata_i[SIZEW-1:0] == '0);

    assign set_flags = {bad_req, recv.got && recv.crc_err, recv.got, send.sent};
    assign clr_flags = (wr && reg_addr_i == REG_CTRL_FLAGS) ?
                       reg_wdata_i[FLAG_LSB +: NFLAGS] : '0;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            reg_ack_o <= 1'b0;
            start_q   <= 1'b0;
            flags     <= '0;
            enables   <= '0;
        end else begin
            reg_ack_o <= req;
            start_q   <= size_wr && !bad_req;
            flags     <= (flags & ~clr_flags) | set_flags;  // a new event wins
            if (wr && reg_addr_i == REG_CTRL_FLAGS) begin
                enables <= reg_wdata_i[ENABLE_LSB +: NFLAGS];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr && reg_addr_i == REG_SEND_DEST) begin
            dest_q     <= reg_wdata_i[EAW-1:0];
            send_hdr_q <= reg_wdata_i[DW-1:DW-HDW];
        end
        if (size_wr && !bad_req) begin
            size_q <= reg_wdata_i[SIZEW-1:0];
        end
        if (recv.got) begin
            rsrc_q  <= recv.src_e_addr;
            rhdr_q  <= recv.hdr_data;
            rsize_q <= recv.size;
        end
        reg_rdata_o <= rdata_d;
    end

    always_comb begin
        rdata_d = '0;
        case (reg_addr_i)
            REG_STATUS:     rdata_d[NFLAGS-1:0] = flags;
            REG_CTRL_FLAGS: begin
                rdata_d[0]                       = send.busy;
                rdata_d[FLAG_LSB +: NFLAGS]      = flags;
                rdata_d[ENABLE_LSB +: NFLAGS]    = enables;
            end
            REG_SEND_DEST:  rdata_d = {send_hdr_q, {(DW - HDW - EAW){1'b0}}, dest_q};
            REG_SEND_SIZE:  rdata_d[SIZEW-1:0] = size_q;
            REG_RECV_SRC:   rdata_d = {rhdr_q, {(DW - HDW - EAW){1'b0}}, rsrc_q};
            REG_RECV_SIZE:  rdata_d[SIZEW-1:0] = rsize_q;
            default:        rdata_d = '0;
        endcase
    end

    assign send.start       = start_q;
    assign send.dest_e_addr = dest_q;
    assign send.hdr_data    = send_hdr_q;
    assign send.size        = size_q;

    assign irq_o = |(flags & enables);

endmodule

`default_nettype wire

// ==== tests/ni_core_assert.sv ====
/* ni_core checker: credit and flit rules as concurrent assertions,
   bound into the top level */
`timescale 1ns/10ps
`default_nettype none

module ni_core_assert #(
    parameter int LB = 8
) (
    input wire                      clk,
    input wire                      reset,
    input wire                      flit_out_wr_i,
    input wire                      credit_in_i,
    input wire [$clog2(LB+1)-1:0]   credit_cnt_i,
    input wire                      flit_in_wr_i,
    input wire                      credit_out_i
);

    int credits_left;   // send credits seen on the network ports
    int buf_fill;       // flits held in the receive buffer

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            credits_left <= LB;
            buf_fill     <= 0;
        end else begin
            credits_left <= credits_left - int'(flit_out_wr_i) + int'(credit_in_i);
            buf_fill     <= buf_fill + int'(flit_in_wr_i) - int'(credit_out_i);
        end
    end

    // every flit written needs a credit
    no_write_without_credit: assert property (@(posedge clk) disable iff (reset)
        flit_out_wr_i |-> (credits_left > 0))
        else $error("flit written while the send credit count is zero");

    credit_within_depth: assert property (@(posedge clk) disable iff (reset)
        int'(credit_cnt_i) <= LB)
        else $error("send credit count above the buffer depth");

    // credits come back only for popped flits
    no_credit_from_empty: assert property (@(posedge clk) disable iff (reset)
        credit_out_i |-> (buf_fill > 0))
        else $error("credit returned while the flit buffer is empty");

endmodule

bind ni_core ni_core_assert #(.LB(LB)) core_assert (
    .clk          (clk),
    .reset        (reset),
    .flit_out_wr_i(flit_out_wr_o),
    .credit_in_i  (credit_in_i),
    .credit_cnt_i (packetizer.credit_cnt),
    .flit_in_wr_i (flit_in_wr_i),
    .credit_out_i (credit_out_o)
);

`default_nettype wire

// ==== tests/ni_core_tb.sv ====
/* ni_core testbench: loopback network model, register and stream stimulus,
   reference CRC model and checks on rx words, flits and registers */
`timescale 1ns/10ps
`default_nettype none

module ni_core_tb;
    import ni_pkg::*;

    localparam logic [EAW-1:0] MY_ADDR   = 8'h5A;
    localparam logic [31:0]    FLIP_MASK = 32'h0000_0100;   // bit hit by the network

    logic             clk;
    logic             reset;
    logic [EAW-1:0]   current_e_addr_i;
    flit_t            flit_out_o;
    logic             flit_out_wr_o;
    logic             credit_in_i;
    flit_t            flit_in_i;
    logic             flit_in_wr_i;
    logic             credit_out_o;
    logic [DW-1:0]    tx_data_i;
    logic             tx_valid_i;
    logic             tx_ready_o;
    logic [DW-1:0]    rx_data_o;
    logic             rx_valid_o;
    logic             rx_ready_i;
    logic             reg_wr_i;
    logic             reg_rd_i;
    reg_addr_e        reg_addr_i;
    logic [DW-1:0]    reg_wdata_i;
    logic [DW-1:0]    reg_rdata_o;
    logic             reg_ack_o;
    logic             irq_o;

    integer           seed = 32'hadb9_c0ec;
    logic [31:0]      tx_words[$];
    logic [31:0]      exp_rx[$];
    flit_t            net_flits[$];
    int               net_times[$];
    logic [31:0]      exp_crc;
    logic [EAW-1:0]   exp_dest;
    logic [HDW-1:0]   exp_hdr;
    logic [3:0]       irq_en = 4'b0000;
    logic             corrupt_next = 1'b0;
    logic             credit_pend = 1'b0;
    logic             bp_mode = 1'b0;     // long rx stalls
    int               bp_left = 0;
    int               cycle_no = 0;
    int               last_rel = 0;
    int               hdr_count = 0;

    ni_core #(.LB(8)) dut (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            abort_run($sformatf("ERR %0t: %s is %h, expected %h", $time, what, actual,
                                expected));
        end
    endtask

    // same CRC32 rule as the DUT: msb first, all ones start, no final inversion
    function automatic logic [31:0] ref_crc(input logic [31:0] words[$]);
        logic [31:0] c;
        logic        fb;
        c = 32'hFFFF_FFFF;
        foreach (words[k]) begin
            for (int i = 31; i >= 0; i--) begin
                fb = c[31] ^ words[k][i];
                c  = {c[30:0], 1'b0} ^ (fb ? 32'h04C1_1DB7 : 32'h0);
            end
        end
        return c;
    endfunction

    task automatic reg_access(input logic wr, input reg_addr_e addr,
                              input logic [31:0] wdata, output logic [31:0] rdata);
        int cycles;
        @(posedge clk);
        reg_wr_i    <= wr;
        reg_rd_i    <= !wr;
        reg_addr_i  <= addr;
        reg_wdata_i <= wdata;
        @(posedge clk);
        reg_wr_i <= 1'b0;
        reg_rd_i <= 1'b0;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
            if (cycles > 8) begin
                abort_run("register request was never acknowledged");
            end
        end while (!reg_ack_o);
        check_value(32'(cycles), 32'd1, "register ack latency");
        rdata = reg_rdata_o;
    endtask

    task automatic reg_write(input reg_addr_e addr, input logic [31:0] data);
        logic [31:0] unused;
        reg_access(1'b1, addr, data, unused);
    endtask

    task automatic reg_read(input reg_addr_e addr, output logic [31:0] data);
        reg_access(1'b0, addr, '0, data);
    endtask

    task automatic read_expect(input reg_addr_e addr, input logic [31:0] exp,
                               input string what);
        logic [31:0] v;
        reg_read(addr, v);
        check_value(v, exp, what);
    endtask

    // poll CTRL_FLAGS until the given bit is set
    task automatic wait_flag(input int bit_idx, input string what);
        logic [31:0] v;
        int          polls;
        v     = '0;
        polls = 0;
        while (!v[bit_idx]) begin
            if (polls == 3000) begin
                abort_run({"timeout waiting for the ", what, " flag"});
            end
            reg_read(REG_CTRL_FLAGS, v);
            polls++;
        end
    endtask

    task automatic start_packet(input int size, input logic corrupt);
        logic [31:0] words[$];
        logic [31:0] w;
        reg_write(REG_CTRL_FLAGS, (32'(irq_en) << 8) | 32'h1E);   // clear old flags
        exp_dest = EAW'($random(seed));
        exp_hdr  = HDW'($random(seed));
        for (int i = 0; i < size; i++) begin
            w = $random(seed);
            words.push_back(w);
            tx_words.push_back(w);
            exp_rx.push_back((corrupt && i == 0) ? (w ^ FLIP_MASK) : w);
        end
        exp_crc      = ref_crc(words);
        corrupt_next = corrupt;
        reg_write(REG_SEND_DEST, {exp_hdr, 8'h00, exp_dest});
        reg_write(REG_SEND_SIZE, 32'(size));
    endtask

    task automatic finish_packet(input int size, input logic corrupt, input logic invalid);
        logic [31:0] v;
        wait_flag(2, "got_packet");
        check_value(32'(exp_rx.size()), 32'd0, "rx words still missing");
        read_expect(REG_RECV_SRC, {exp_hdr, 8'h00, MY_ADDR}, "RECV_SRC");
        read_expect(REG_RECV_SIZE, 32'(size), "RECV_SIZE");
        reg_read(REG_CTRL_FLAGS, v);
        check_value(32'(v[4:0]), 32'({invalid, corrupt, 3'b110}), "flags after packet");
    endtask

    // network model: flits out to flits in with 0..3 cycles delay, credits looped back
    always @(negedge clk) begin : net_capture
        flit_t f;
        int    rel;
        credit_pend = !reset && credit_out_o;
        if (!reset && flit_out_wr_o) begin
            f = flit_out_o;
            if (f.flag == FLAG_HDR) begin
                hdr_count++;
                check_value(32'(f.payload.hdr.dest_e_addr), 32'(exp_dest), "header dest");
                check_value(32'(f.payload.hdr.src_e_addr), 32'(MY_ADDR), "header src");
                check_value(32'(f.payload.hdr.hdr_data), 32'(exp_hdr), "header data");
            end else if (f.flag == FLAG_TAIL) begin
                check_value(f.payload.data, exp_crc, "tail crc");
            end else if (corrupt_next) begin
                f.payload.data = f.payload.data ^ FLIP_MASK;
                corrupt_next   = 1'b0;
            end
            rel = cycle_no + 1 + int'($unsigned($random(seed)) % 4);
            if (rel < last_rel) begin
                rel = last_rel;     // keep flit order
            end
            last_rel = rel;
            net_flits.push_back(f);
            net_times.push_back(rel);
        end
    end

    always @(posedge clk) begin
        cycle_no++;
        credit_in_i <= credit_pend;
        if (net_flits.size() != 0 && net_times[0] <= cycle_no) begin
            flit_in_i    <= net_flits.pop_front();
            flit_in_wr_i <= 1'b1;
            void'(net_times.pop_front());
        end else begin
            flit_in_wr_i <= 1'b0;
        end
    end

    // rx consumer, long low stretches in back-pressure mode
    always @(posedge clk) begin
        if (!bp_mode) begin
            rx_ready_i <= 1'b1;
        end else if (bp_left > 0) begin
            bp_left--;
        end else begin
            rx_ready_i <= !rx_ready_i;
            bp_left = rx_ready_i ? 10 + int'($unsigned($random(seed)) % 30)
                                 : 1 + int'($unsigned($random(seed)) % 6);
        end
    end

    initial begin : tx_driver
        logic fire;
        forever begin
            @(negedge clk);
            fire = tx_valid_i && tx_ready_o;
            @(posedge clk);
            if (fire) begin
                void'(tx_words.pop_front());
            end
            tx_valid_i <= (tx_words.size() != 0);
            tx_data_i  <= (tx_words.size() != 0) ? tx_words[0] : '0;
        end
    end

    // compare rx words in the cycle they transfer
    always @(negedge clk) begin
        if (!reset && rx_valid_o && rx_ready_i) begin
            if (exp_rx.size() == 0) begin
                abort_run("rx word delivered with no word expected");
            end else begin
                check_value(rx_data_o, exp_rx.pop_front(), "rx word");
            end
        end
    end

    initial begin
        logic [31:0] v;
        int          hdr_before;
        int          size;
        reset            = 1'b1;
        current_e_addr_i = MY_ADDR;
        credit_in_i      = 1'b0;
        flit_in_i        = '0;
        flit_in_wr_i     = 1'b0;
        tx_data_i        = '0;
        tx_valid_i       = 1'b0;
        rx_ready_i       = 1'b1;
        reg_wr_i         = 1'b0;
        reg_rd_i         = 1'b0;
        reg_addr_i       = REG_STATUS;
        reg_wdata_i      = '0;
        repeat (16) @(posedge clk);
        reset <= 1'b0;

        read_expect(REG_CTRL_FLAGS, 32'h0, "CTRL_FLAGS after reset");
        read_expect(REG_STATUS, 32'h0, "STATUS after reset");
        reg_write(REG_CTRL_FLAGS, 32'h0000_0F00);
        read_expect(REG_CTRL_FLAGS, 32'h0000_0F00, "enables read back");
        reg_write(REG_SEND_DEST, 32'hBEEF_0033);
        read_expect(REG_SEND_DEST, 32'hBEEF_0033, "SEND_DEST read back");
        check_value(32'(irq_o), 32'd0, "irq with no flags");
        reg_write(REG_CTRL_FLAGS, 32'h0);

        size = 1 + int'($unsigned($random(seed)) % 16);
        start_packet(size, 1'b0);
        finish_packet(size, 1'b0, 1'b0);

        bp_mode = 1'b1;     // sender runs out of credits
        start_packet(40, 1'b0);
        finish_packet(40, 1'b0, 1'b0);
        bp_mode = 1'b0;

        hdr_before = hdr_count;
        start_packet(30, 1'b0);
        reg_write(REG_SEND_SIZE, 32'd5);    // rejected while busy
        finish_packet(30, 1'b0, 1'b1);
        check_value(32'(hdr_count - hdr_before), 32'd1, "packets started while busy");

        reg_write(REG_CTRL_FLAGS, 32'h0000_001E);
        hdr_before = hdr_count;
        reg_write(REG_SEND_SIZE, 32'd0);
        reg_read(REG_CTRL_FLAGS, v);
        check_value(32'(v[4:0]), 32'h10, "flags after size zero");
        check_value(32'(hdr_count), 32'(hdr_before), "header sent for size zero");

        irq_en = 4'b0100;
        start_packet(12, 1'b1);
        check_value(32'(irq_o), 32'd0, "irq before crc error");
        finish_packet(12, 1'b1, 1'b0);
        check_value(32'(irq_o), 32'd1, "irq on crc error");

        reg_write(REG_CTRL_FLAGS, (32'(irq_en) << 8) | 32'h8);
        check_value(32'(irq_o), 32'd0, "irq after crc_err clear");
        reg_read(REG_CTRL_FLAGS, v);
        check_value(32'(v[3]), 32'd0, "crc_err after clear");
        reg_write(REG_CTRL_FLAGS, 32'h0000_001E);
        read_expect(REG_STATUS, 32'h0, "STATUS after clearing all");

        $display("Simulation passed");
        $finish;
    end

endmodule

`default_nettype wire
